//--- bench/cacheTb.sv
////////////////////
// Testbench for cacheTop with NumSets 16 and MemLatency 3
// Table addresses keep backing-memory line indices distinct to avoid aliasing
////////////////////
`timescale 1ns/1ps

module cacheTb;

  localparam int NumSets = 16;
  localparam int MemLatency = 3;
  localparam int ClockPeriod = 20;
  localparam int ResetCycles = 16;
  localparam int NumSteps = 18;
  localparam int CyclesPerStep = 40 + 4 * MemLatency;
  localparam int IndexBits = $clog2(NumSets);
  localparam int TagBits = cachePkg::AddrBits - IndexBits - cachePkg::LineOffsetBits;

  // One table row, the request followed by the expected response
  typedef struct packed {
    logic                          write;
    logic [cachePkg::AddrBits-1:0] addr;
    logic [cachePkg::WordBits-1:0] data;
    logic [cachePkg::WordBits-1:0] expData;
    logic                          expHit;
  } stepT;

  logic                clk;
  logic                reset;
  logic                reqValid;
  logic                reqReady;
  cachePkg::cacheReqT  req;
  logic                respValid;
  logic                respReady;
  cachePkg::cacheRespT resp;

  stepT   steps [NumSteps];
  integer seed;

  // Reference model state
  logic [cachePkg::WordBits-1:0] shadow [logic [cachePkg::AddrBits-1:0]];
  logic [TagBits-1:0]            refTag [NumSets][2];
  logic                          refValid [NumSets][2];
  logic                          refLru [NumSets];

  cacheTop #(
    .NumSets(NumSets),
    .MemLatency(MemLatency)
  ) dut_i (
    .clk, .reset,
    .reqValid, .reqReady, .req,
    .respValid, .respReady, .resp
  );

  initial begin
    clk = 1'b0;
    forever #(ClockPeriod / 2) clk = ~clk;
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic stopWithFailure(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  // Sets 4 and 7 each see three tags, so both exercise LRU eviction
  function automatic void loadSteps();
    steps[0]  = '{1'b0, 32'h0000_0140, 32'h0, 32'hFFFF_FEBF, 1'b0};
    steps[1]  = '{1'b0, 32'h0000_0140, 32'h0, 32'hFFFF_FEBF, 1'b1};
    steps[2]  = '{1'b1, 32'h0000_0144, 32'hA5A5_0001, 32'hA5A5_0001, 1'b1};
    steps[3]  = '{1'b0, 32'h0000_0144, 32'h0, 32'hA5A5_0001, 1'b1};
    steps[4]  = '{1'b0, 32'h0000_0240, 32'h0, 32'hFFFF_FDBF, 1'b0};
    steps[5]  = '{1'b0, 32'h0000_0140, 32'h0, 32'hFFFF_FEBF, 1'b1};
    steps[6]  = '{1'b0, 32'h0000_0248, 32'h0, 32'hFFFF_FDB7, 1'b1};
    steps[7]  = '{1'b0, 32'h0000_0340, 32'h0, 32'hFFFF_FCBF, 1'b0};
    steps[8]  = '{1'b0, 32'h0000_0144, 32'h0, 32'hA5A5_0001, 1'b0};
    steps[9]  = '{1'b0, 32'h0000_0240, 32'h0, 32'hFFFF_FDBF, 1'b0};
    steps[10] = '{1'b1, 32'h0000_0A7C, 32'h1234_5678, 32'h1234_5678, 1'b0};
    steps[11] = '{1'b0, 32'h0000_0A7C, 32'h0, 32'h1234_5678, 1'b1};
    steps[12] = '{1'b1, 32'h0000_0B70, 32'hDEAD_BEEF, 32'hDEAD_BEEF, 1'b0};
    steps[13] = '{1'b0, 32'h0000_0C74, 32'h0, 32'hFFFF_F38B, 1'b0};
    steps[14] = '{1'b0, 32'h0000_0A7C, 32'h0, 32'h1234_5678, 1'b0};
    steps[15] = '{1'b0, 32'h0000_0B70, 32'h0, 32'hDEAD_BEEF, 1'b0};
    steps[16] = '{1'b0, 32'hFFFF_FFF0, 32'h0, 32'h0000_000F, 1'b0};
    steps[17] = '{1'b0, 32'h0000_0A7C, 32'h0, 32'h1234_5678, 1'b1};
  endfunction

  function automatic void resetModel();
    for (int s = 0; s < NumSets; s++) begin
      refValid[s][0] = 1'b0;
      refValid[s][1] = 1'b0;
      refLru[s] = 1'b0;
    end
  endfunction

  // Words never written read as the inverse of their byte address
  function automatic logic [cachePkg::WordBits-1:0] shadowRead(
    input logic [cachePkg::AddrBits-1:0] wordAddr
  );
    if (shadow.exists(wordAddr)) begin
      return shadow[wordAddr];
    end
    return ~wordAddr;
  endfunction

  // Predicts one access and updates tags, LRU and shadow memory
  task automatic predictAccess(input stepT s, output logic [31:0] data, output logic hit);
    logic [IndexBits-1:0]          index;
    logic [TagBits-1:0]            tag;
    logic [cachePkg::AddrBits-1:0] wordAddr;
    logic                          way;
    index = s.addr[cachePkg::LineOffsetBits +: IndexBits];
    tag = s.addr[cachePkg::AddrBits-1 -: TagBits];
    wordAddr = {s.addr[31:2], 2'b00};
    hit = 1'b0;
    way = refLru[index];
    for (int w = 0; w < 2; w++) begin
      if (refValid[index][w] && refTag[index][w] == tag) begin
        hit = 1'b1;
        way = (w == 1);
      end
    end
    // A miss fills the LRU way, and either way the other one is next out
    if (!hit) begin
      refValid[index][way] = 1'b1;
      refTag[index][way] = tag;
    end
    refLru[index] = ~way;
    if (s.write) begin
      shadow[wordAddr] = s.data;
    end
    data = shadowRead(wordAddr);
  endtask

  // reqReady is read at the falling edge, where it is stable
  task automatic sendRequest(input stepT s);
    @(negedge clk);
    req.write = s.write;
    req.addr = s.addr;
    req.data = s.data;
    reqValid = 1'b1;
    while (!reqReady) @(negedge clk);
    @(negedge clk);
    reqValid = 1'b0;
  endtask

  // Random respReady stalls, the held response must not change
  task automatic waitResponse(output cachePkg::cacheRespT captured);
    logic                done;
    logic                seen;
    cachePkg::cacheRespT first;
    done = 1'b0;
    seen = 1'b0;
    while (!done) begin
      @(negedge clk);
      respReady = ($random(seed) % 4) != 0;
      if (respValid) begin
        if (!seen) begin
          first = resp;
          seen = 1'b1;
        end
        assert (resp == first) else stopWithFailure($sformatf(
          "CHECK FAILED at %0t: response changed while stalled", $time));
        if (respReady) begin
          captured = resp;
          done = 1'b1;
        end
      end
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    logic [31:0]         predData;
    logic                predHit;
    cachePkg::cacheRespT got;
    seed = 32'h6d4f_46b7;
    reset = 1'b1;
    reqValid = 1'b0;
    req = '0;
    respReady = 1'b0;
    loadSteps();
    resetModel();
    repeat (ResetCycles) @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < NumSteps; i++) begin
      // The table's expected columns must agree with the model first
      predictAccess(steps[i], predData, predHit);
      assert (predData == steps[i].expData && predHit == steps[i].expHit)
        else stopWithFailure($sformatf(
          "CHECK FAILED at %0t: step %0d table %h/%0b but model %h/%0b", $time, i,
          steps[i].expData, steps[i].expHit, predData, predHit));
      sendRequest(steps[i]);
      waitResponse(got);
      assert (got.data == steps[i].expData) else stopWithFailure($sformatf(
        "CHECK FAILED at %0t: step %0d data %h, expected %h", $time, i,
        got.data, steps[i].expData));
      assert (got.hit == steps[i].expHit) else stopWithFailure($sformatf(
        "CHECK FAILED at %0t: step %0d hit %0b, expected %0b", $time, i,
        got.hit, steps[i].expHit));
    end
    $display(">>> PASS");
    $finish;
  end

  // Budget covers reset plus the worst miss path for every row
  initial begin
    repeat (ResetCycles + NumSteps * CyclesPerStep) @(posedge clk);
    stopWithFailure("Watchdog expired, the cache run hung waiting for a handshake");
  end

endmodule

//--- bench/cacheTop_assertions.sv
////////////////////
// Handshake checks bound into cacheTop
// Stability checks are skipped while reset is high
////////////////////
`timescale 1ns/1ps

module cacheTopAssertions (
  input logic                clk,
  input logic                reset,
  input logic                reqValid,
  input logic                reqReady,
  input cachePkg::cacheReqT  req,
  input logic                respValid,
  input logic                respReady,
  input cachePkg::cacheRespT resp
);

  // Set by an accepted request and cleared when its response is taken
  logic inFlight;

  always_ff @(posedge clk) begin
    if (reset) begin
      inFlight <= 1'b0;
    end else if (reqValid && reqReady) begin
      inFlight <= 1'b1;
    end else if (respValid && respReady) begin
      inFlight <= 1'b0;
    end
  end

  // A stalled request keeps valid and payload until accepted
  reqHeld: assert property (@(posedge clk) disable iff (reset)
    reqValid && !reqReady |=> reqValid && $stable(req))
    else $error("Request dropped or changed while stalled");

  // A stalled response keeps valid and payload until taken
  respHeld: assert property (@(posedge clk) disable iff (reset)
    respValid && !respReady |=> respValid && $stable(resp))
    else $error("Response dropped or changed while stalled");

  // Only one request in flight, so no accept until its response is taken
  oneInFlight: assert property (@(posedge clk) disable iff (reset)
    inFlight |-> !reqReady)
    else $error("reqReady high while a request is in flight");

  // A response only follows an accepted request, so reqReady is low under it
  respFollowsReq: assert property (@(posedge clk) disable iff (reset)
    respValid |-> inFlight)
    else $error("respValid high with no request in flight");

  // Checked the cycle after each reset edge, once the FSM has cleared
  quietInReset: assert property (@(posedge clk) reset |=> !respValid)
    else $error("respValid high during reset");

endmodule

bind cacheTop cacheTopAssertions assertionsI (
  .clk      (clk),
  .reset    (reset),
  .reqValid (reqValid),
  .reqReady (reqReady),
  .req      (req),
  .respValid(respValid),
  .respReady(respReady),
  .resp     (resp)
);

//--- filelist.f
source/cachePkg.sv
source/cacheSram.sv
source/cacheWay.sv
source/cacheController.sv
source/backingMemory.sv
source/cacheTop.sv
bench/cacheTop_assertions.sv
bench/cacheTb.sv

//--- run.sh
#!/bin/sh
# Builds the cache testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module cacheTb \
  -f filelist.f \
  --Mdir obj_dir -o cacheSim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/cacheSim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

exit 0

//--- source/backingMemory.sv
////////////////////
// Line-wide memory model, read data returns MemLatency cycles after accept
// Lines never written read as the inverse of each word's byte address
// Written lines alias modulo the array depth
////////////////////
`timescale 1ns/1ps

module backingMemory #(
  parameter int NumSets = 16,
  parameter int MemLatency = 3,
  localparam int MemLines = (NumSets > 256) ? NumSets : 256,
  localparam int LineIndexBits = $clog2(MemLines),
  localparam int CountBits = $clog2(MemLatency + 1)
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              memReqValid,
  output logic              memReqReady,
  input  cachePkg::memReqT  memReq,
  output logic              memRespValid,
  output cachePkg::memRespT memResp
);

  logic [cachePkg::LineBits-1:0] mem [MemLines];
  logic [MemLines-1:0]           written;
  logic                          pending;
  logic [CountBits-1:0]          count;
  logic [cachePkg::AddrBits-1:0] readAddr;
  logic [LineIndexBits-1:0]      reqIndex;
  logic [LineIndexBits-1:0]      readIndex;

  // Reset contents of a line, built from its own address
  function automatic logic [cachePkg::LineBits-1:0] defaultLine(
    input logic [cachePkg::AddrBits-1:0] lineAddr
  );
    logic [cachePkg::LineBits-1:0] line;
    for (int w = 0; w < cachePkg::LineWords; w++) begin
      line[w*cachePkg::WordBits +: cachePkg::WordBits] = cachePkg::WordBits'(
        ~(lineAddr + cachePkg::AddrBits'(w * (cachePkg::WordBits / 8))));
    end
    return line;
  endfunction

  assign reqIndex = memReq.lineAddr[cachePkg::LineOffsetBits +: LineIndexBits];
  assign readIndex = readAddr[cachePkg::LineOffsetBits +: LineIndexBits];

  // Only one read is outstanding at a time
  assign memReqReady = ~pending;

  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= 1'b0;
      count <= '0;
      memRespValid <= 1'b0;
      written <= '0;
    end else begin
      memRespValid <= 1'b0;
      if (memReqValid && memReqReady) begin
        if (memReq.write) begin
          written[reqIndex] <= 1'b1;
        end else begin
          pending <= 1'b1;
          count <= CountBits'(MemLatency - 1);
        end
      end else if (pending) begin
        if (count == '0) begin
          pending <= 1'b0;
          memRespValid <= 1'b1;
        end else begin
          count <= count - 1'b1;
        end
      end
    end
  end

  // Line data and the pending address
  always_ff @(posedge clk) begin
    if (memReqValid && memReqReady) begin
      if (memReq.write) begin
        mem[reqIndex] <= memReq.line;
      end else begin
        readAddr <= memReq.lineAddr;
      end
    end
    if (pending && count == '0) begin
      memResp.line <= written[readIndex] ? mem[readIndex] : defaultLine(readAddr);
    end
  end

endmodule

//--- source/cacheController.sv
////////////////////
// Cache FSM with one request in flight, hits respond two cycles after accept
// Misses write back a dirty victim, fill, then look up again
// One LRU bit per set names the way to replace next
////////////////////
`timescale 1ns/1ps

module cacheController #(
  parameter int NumSets = 16,
  localparam int IndexBits = $clog2(NumSets),
  localparam int TagBits = cachePkg::AddrBits - IndexBits - cachePkg::LineOffsetBits
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                reqValid,
  output logic                                reqReady,
  input  cachePkg::cacheReqT                  req,
  output logic                                respValid,
  input  logic                                respReady,
  output cachePkg::cacheRespT                 resp,
  output logic [IndexBits-1:0]                waySetIndex,
  output logic [TagBits-1:0]                  wayLookupTag,
  output logic [cachePkg::LineWords-1:0]      wayWordEnable,
  output logic [cachePkg::LineBits-1:0]       wayWriteLine,
  output logic [1:0]                          wayWriteEnable,
  output logic [1:0]                          wayTagWriteEnable,
  output logic [1:0]                          waySetValid,
  output logic [1:0]                          waySetDirty,
  output logic [1:0]                          wayClearDirty,
  input  logic [1:0]                          wayHit,
  input  logic [1:0][cachePkg::LineBits-1:0]  wayLine,
  input  logic [1:0][TagBits-1:0]             wayVictimTag,
  input  logic [1:0]                          wayVictimDirty,
  output logic                                memReqValid,
  input  logic                                memReqReady,
  output cachePkg::memReqT                    memReq,
  input  logic                                memRespValid,
  input  cachePkg::memRespT                   memResp
);

  // Compare is the cycle after the RAM read, where the hit is known
  typedef enum logic [2:0] {
    sIdle,
    sLookup,
    sCompare,
    sRespond,
    sWriteback,
    sFillWait,
    sRefill
  } stateT;

  stateT                              state;
  cachePkg::cacheReqT                 reqReg;
  logic                               missSeen;
  logic                               fillSent;
  logic [NumSets-1:0]                 lru;

  // Fields of the accepted request
  logic [IndexBits-1:0]               reqIndex;
  logic [TagBits-1:0]                 reqTag;
  logic [cachePkg::WordSelBits-1:0]   reqWord;
  logic                               anyHit;
  logic                               hitWay;
  logic                               victim;

  assign reqIndex = reqReg.addr[cachePkg::LineOffsetBits +: IndexBits];
  assign reqTag = reqReg.addr[cachePkg::AddrBits-1 -: TagBits];
  assign reqWord = reqReg.addr[cachePkg::ByteOffsetBits +: cachePkg::WordSelBits];
  assign anyHit = |wayHit;
  assign hitWay = wayHit[1];
  assign victim = lru[reqIndex];

  // Both ways always look at the set and tag of the held request
  assign waySetIndex = reqIndex;
  assign wayLookupTag = reqTag;

  assign reqReady = (state == sIdle);
  assign respValid = (state == sRespond);

  ////////////////////
  // Way and memory commands
  ////////////////////

  always_comb begin
    wayWordEnable = '0;
    wayWriteLine = {cachePkg::LineWords{reqReg.data}};
    wayWriteEnable = '0;
    wayTagWriteEnable = '0;
    waySetValid = '0;
    waySetDirty = '0;
    wayClearDirty = '0;

    // Write hit, one word is stored and the line turns dirty
    if (state == sCompare && anyHit && reqReg.write) begin
      wayWriteEnable[hitWay] = 1'b1;
      wayWordEnable[reqWord] = 1'b1;
      waySetDirty[hitWay] = 1'b1;
    end

    // Fill data goes straight into the victim way as a clean line
    if (state == sFillWait && memRespValid) begin
      wayWriteLine = memResp.line;
      wayWordEnable = '1;
      wayWriteEnable[victim] = 1'b1;
      wayTagWriteEnable[victim] = 1'b1;
      waySetValid[victim] = 1'b1;
      wayClearDirty[victim] = 1'b1;
    end
  end

  // Writeback sends the victim line, every other request is the fill read
  always_comb begin
    memReqValid = (state == sWriteback) || (state == sFillWait && !fillSent);
    memReq.line = wayLine[victim];
    if (state == sWriteback) begin
      memReq.write = 1'b1;
      memReq.lineAddr = {wayVictimTag[victim], reqIndex, {cachePkg::LineOffsetBits{1'b0}}};
    end else begin
      memReq.write = 1'b0;
      memReq.lineAddr = {reqTag, reqIndex, {cachePkg::LineOffsetBits{1'b0}}};
    end
  end

  ////////////////////
  // FSM and LRU
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= sIdle;
      missSeen <= 1'b0;
      fillSent <= 1'b0;
      lru <= '0;
    end else begin
      case (state)
        sIdle: begin
          if (reqValid) begin
            missSeen <= 1'b0;
            state <= sLookup;
          end
        end
        // The RAMs read the set of the new request in this cycle
        sLookup: state <= sCompare;
        sCompare: begin
          if (anyHit) begin
            lru[reqIndex] <= ~hitWay;
            state <= sRespond;
          end else begin
            missSeen <= 1'b1;
            fillSent <= 1'b0;
            state <= wayVictimDirty[victim] ? sWriteback : sFillWait;
          end
        end
        sRespond: begin
          if (respReady) begin
            state <= sIdle;
          end
        end
        sWriteback: begin
          if (memReqReady) begin
            state <= sFillWait;
          end
        end
        sFillWait: begin
          if (memReqReady && !fillSent) begin
            fillSent <= 1'b1;
          end
          // The fresh line is the most recent, the other way is next out
          if (memRespValid) begin
            lru[reqIndex] <= ~victim;
            state <= sRefill;
          end
        end
        // Re-read the set so the response comes from the hit path
        sRefill: state <= sCompare;
        default: state <= sIdle;
      endcase
    end
  end

  // Request and response payloads carry no reset
  always_ff @(posedge clk) begin
    if (reqValid && reqReady) begin
      reqReg <= req;
    end
    if (state == sCompare && anyHit) begin
      resp.data <= reqReg.write ? reqReg.data
                 : wayLine[hitWay][reqWord*cachePkg::WordBits +: cachePkg::WordBits];
      resp.hit <= ~missSeen;
    end
  end

endmodule

//--- source/cachePkg.sv
////////////////////
// Shared widths and bus structs for the write-back cache
// The line is fixed at four 32-bit words, so all structs have fixed widths
// Tag and index widths depend on NumSets and live in the modules
////////////////////
package cachePkg;

  // Byte address and data word widths
  localparam int AddrBits = 32;
  localparam int WordBits = 32;

  // Four words per line keeps the memory structs at a fixed width
  localparam int LineWords = 4;
  localparam int LineBits = LineWords * WordBits;

  // Address field widths below the set index
  localparam int ByteOffsetBits = $clog2(WordBits / 8);
  localparam int WordSelBits = $clog2(LineWords);
  localparam int LineOffsetBits = ByteOffsetBits + WordSelBits;

  ////////////////////
  // Processor side
  ////////////////////

  // One processor request, a read when write is low
  typedef struct packed {
    logic                write;
    logic [AddrBits-1:0] addr;
    logic [WordBits-1:0] data;
  } cacheReqT;

  // One processor response
  // Hit is high only when no backing-memory access was needed
  typedef struct packed {
    logic [WordBits-1:0] data;
    logic                hit;
  } cacheRespT;

  ////////////////////
  // Memory side
  ////////////////////

  // Line-wide request, the offset bits of lineAddr are always zero
  typedef struct packed {
    logic                write;
    logic [AddrBits-1:0] lineAddr;
    logic [LineBits-1:0] line;
  } memReqT;

  // Fill data returned for a read request
  typedef struct packed {
    logic [LineBits-1:0] line;
  } memRespT;

endpackage

//--- source/cacheSram.sv
////////////////////
// Single-port RAM, read data one cycle after the address
// Read-first, so a write returns the old contents
////////////////////
`timescale 1ns/1ps

module cacheSram #(
  parameter int Depth = 16,
  parameter int Width = 32
) (
  input  logic                     clk,
  input  logic [$clog2(Depth)-1:0] addr,
  input  logic                     writeEnable,
  input  logic [Width-1:0]         writeData,
  output logic [Width-1:0]         readData
);

  // Storage array with no reset, contents are undefined until written
  logic [Width-1:0] mem [Depth];

  // The read samples the array before the write lands
  always_ff @(posedge clk) begin
    if (writeEnable) begin
      mem[addr] <= writeData;
    end
    readData <= mem[addr];
  end

endmodule

//--- source/cacheTop.sv
////////////////////
// Two-way write-back cache with its backing memory model
// One request at a time, reqReady is high only when idle
////////////////////
`timescale 1ns/1ps

module cacheTop #(
  parameter int NumSets = 16,
  parameter int MemLatency = 3
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                reqValid,
  output logic                reqReady,
  input  cachePkg::cacheReqT  req,
  output logic                respValid,
  input  logic                respReady,
  output cachePkg::cacheRespT resp
);

  localparam int IndexBits = $clog2(NumSets);
  localparam int TagBits = cachePkg::AddrBits - IndexBits - cachePkg::LineOffsetBits;

  // Commands shared by both ways
  logic [IndexBits-1:0]                waySetIndex;
  logic [TagBits-1:0]                  wayLookupTag;
  logic [cachePkg::LineWords-1:0]      wayWordEnable;
  logic [cachePkg::LineBits-1:0]       wayWriteLine;

  // Per-way strobes and results, bit 0 is way 0
  logic [1:0]                          wayWriteEnable;
  logic [1:0]                          wayTagWriteEnable;
  logic [1:0]                          waySetValid;
  logic [1:0]                          waySetDirty;
  logic [1:0]                          wayClearDirty;
  logic [1:0]                          wayHit;
  logic [1:0][cachePkg::LineBits-1:0]  wayLine;
  logic [1:0][TagBits-1:0]             wayVictimTag;
  logic [1:0]                          wayVictimDirty;

  // Backing memory bus
  logic                                memReqValid;
  logic                                memReqReady;
  cachePkg::memReqT                    memReq;
  logic                                memRespValid;
  cachePkg::memRespT                   memResp;

  cacheController #(
    .NumSets(NumSets)
  ) controller (
    .clk, .reset,
    .reqValid, .reqReady, .req,
    .respValid, .respReady, .resp,
    .waySetIndex, .wayLookupTag, .wayWordEnable, .wayWriteLine,
    .wayWriteEnable, .wayTagWriteEnable, .waySetValid, .waySetDirty, .wayClearDirty,
    .wayHit, .wayLine, .wayVictimTag, .wayVictimDirty,
    .memReqValid, .memReqReady, .memReq,
    .memRespValid, .memResp
  );

  for (genvar w = 0; w < 2; w++) begin : wayGen
    cacheWay #(
      .NumSets(NumSets)
    ) way (
      .clk           (clk),
      .reset         (reset),
      .setIndex      (waySetIndex),
      .lookupTag     (wayLookupTag),
      .writeEnable   (wayWriteEnable[w]),
      .wordEnable    (wayWordEnable),
      .tagWriteEnable(wayTagWriteEnable[w]),
      .writeLine     (wayWriteLine),
      .setValid      (waySetValid[w]),
      .setDirty      (waySetDirty[w]),
      .clearDirty    (wayClearDirty[w]),
      .readLine      (wayLine[w]),
      .hit           (wayHit[w]),
      .victimDirty   (wayVictimDirty[w]),
      .victimTag     (wayVictimTag[w])
    );
  end

  backingMemory #(
    .NumSets(NumSets),
    .MemLatency(MemLatency)
  ) memory (
    .clk, .reset,
    .memReqValid, .memReqReady, .memReq,
    .memRespValid, .memResp
  );

endmodule

//--- source/cacheWay.sv
////////////////////
// One way of the cache with data, tag, valid and dirty storage
// Hit and victim outputs are valid one cycle after setIndex
// Valid and dirty strobes take effect on the edge after they are registered
////////////////////
`timescale 1ns/1ps

module cacheWay #(
  parameter int NumSets = 16,
  localparam int IndexBits = $clog2(NumSets),
  localparam int TagBits = cachePkg::AddrBits - IndexBits - cachePkg::LineOffsetBits
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [IndexBits-1:0]           setIndex,
  input  logic [TagBits-1:0]             lookupTag,
  input  logic                           writeEnable,
  input  logic [cachePkg::LineWords-1:0] wordEnable,
  input  logic                           tagWriteEnable,
  input  logic [cachePkg::LineBits-1:0]  writeLine,
  input  logic                           setValid,
  input  logic                           setDirty,
  input  logic                           clearDirty,
  output logic [cachePkg::LineBits-1:0]  readLine,
  output logic                           hit,
  output logic                           victimDirty,
  output logic [TagBits-1:0]             victimTag
);

  // Per-set state bits, kept in flops so reset can clear them
  logic [NumSets-1:0]   validBits;
  logic [NumSets-1:0]   dirtyBits;
  logic [TagBits-1:0]   readTag;

  // Index and strobes delayed to line up with the RAM read
  logic [IndexBits-1:0] setIndexD;
  logic                 setValidD;
  logic                 setDirtyD;
  logic                 clearDirtyD;

  ////////////////////
  // Data and tag RAMs
  ////////////////////

  // One word-wide RAM per word lets a single word be written alone
  for (genvar w = 0; w < cachePkg::LineWords; w++) begin : wordGen
    cacheSram #(
      .Depth(NumSets),
      .Width(cachePkg::WordBits)
    ) dataRam (
      .clk        (clk),
      .addr       (setIndex),
      .writeEnable(writeEnable & wordEnable[w]),
      .writeData  (writeLine[w*cachePkg::WordBits +: cachePkg::WordBits]),
      .readData   (readLine[w*cachePkg::WordBits +: cachePkg::WordBits])
    );
  end

  // The tag written on a fill is the tag being looked up
  cacheSram #(
    .Depth(NumSets),
    .Width(TagBits)
  ) tagRam (
    .clk        (clk),
    .addr       (setIndex),
    .writeEnable(tagWriteEnable),
    .writeData  (lookupTag),
    .readData   (readTag)
  );

  ////////////////////
  // Valid and dirty
  ////////////////////

  always_ff @(posedge clk) begin
    setIndexD <= setIndex;
    if (reset) begin
      setValidD <= 1'b0;
      setDirtyD <= 1'b0;
      clearDirtyD <= 1'b0;
    end else begin
      setValidD <= setValid;
      setDirtyD <= setDirty;
      clearDirtyD <= clearDirty;
    end
  end

  // Updates use the delayed index, the same set the RAMs are reading
  always_ff @(posedge clk) begin
    if (reset) begin
      validBits <= '0;
      dirtyBits <= '0;
    end else begin
      if (setValidD) begin
        validBits[setIndexD] <= 1'b1;
      end
      // A set wins over a clear, though the controller never sends both
      if (setDirtyD) begin
        dirtyBits[setIndexD] <= 1'b1;
      end else if (clearDirtyD) begin
        dirtyBits[setIndexD] <= 1'b0;
      end
    end
  end

  // An invalid line never hits and never needs a writeback
  assign hit = validBits[setIndexD] & (readTag == lookupTag);
  assign victimDirty = validBits[setIndexD] & dirtyBits[setIndexD];
  assign victimTag = readTag;

endmodule
